//--- tb.f
+incdir+rtl
+incdir+test
rtl/motion_pkg.sv
rtl/move_buffer_if.sv
rtl/word_command_decoder.sv
rtl/dda_sequencer.sv
rtl/dda_axis.sv
rtl/motion_core.sv
test/motion_core_tb.sv

//--- test/motion_core_tests.svh
// Tests share DUT state in order; config_round_trip leaves both motors enabled at divisor 4

  // Distance covered in one move in accumulator units
  function automatic logic [`MC_DDA_BITS-1:0] travel_of(input motion_pkg::dda_t inc,
      input motion_pkg::dda_t acc, input motion_pkg::duration_t dur);
    logic [`MC_DDA_BITS-1:0] d;
    d = `MC_DDA_BITS'(dur);
    return d * inc + acc * (d * (d - 1) / 2);
  endfunction

  // One step per integer boundary crossed with the fraction carried to the next move
  task automatic account_move(input int m, input motion_pkg::dda_t inc,
                              input motion_pkg::dda_t acc, input motion_pkg::duration_t dur);
    logic [`MC_DDA_BITS-1:0] start;
    logic [`MC_DDA_BITS-1:0] stop;
    start = position_model[m];
    stop = start + travel_of(inc, acc, dur);
    expected_count[m] = expected_count[m] + motion_pkg::duration_t'(
        (stop >> `MC_STEP_FRAC_BITS) - (start >> `MC_STEP_FRAC_BITS));
    position_model[m] = stop;
  endtask

  task automatic send_move(input motion_pkg::motor_mask_t dirs, input motion_pkg::duration_t dur,
                           input motion_pkg::dda_t inc0, input motion_pkg::dda_t acc0,
                           input motion_pkg::dda_t inc1, input motion_pkg::dda_t acc1);
    motion_pkg::word_t resp;
    motion_pkg::word_t payload [5];
    payload[0] = motion_pkg::word_t'(dur);
    payload[1] = inc0;
    payload[2] = acc0;
    payload[3] = inc1;
    payload[4] = acc1;
    wait_buffer_ready();
    send_word({`MC_CMD_MOVE, 54'd0, dirs}, resp);
    compare_word("move header answer", resp, '0);
    for (int i = 0; i < 5; i++) begin
      send_word(payload[i], resp);
      compare_word("move payload answer", resp, '0);
    end
    account_move(0, inc0, acc0, dur);
    account_move(1, inc1, acc1, dur);
  endtask

  // Second word always writes, so a read writes back the value given
  task automatic config_access(input logic [7:0] addr, input logic [31:0] value,
                               output motion_pkg::word_t old);
    motion_pkg::word_t resp;
    send_word({`MC_CMD_CONFIG, 48'd0, addr}, old);
    send_word(motion_pkg::word_t'(value), resp);
    compare_word("config data answer", resp, '0);
  endtask

  task automatic status_read(input logic [7:0] addr, output motion_pkg::word_t resp);
    send_word({`MC_CMD_STATUS, 48'd0, addr}, resp);
  endtask

  task automatic check_steps();
    compare_count("steps motor 0", step_count[0], expected_count[0]);
    compare_count("steps motor 1", step_count[1], expected_count[1]);
  endtask

  task automatic after_reset();
    int errs;
    motion_pkg::word_t resp;
    errs = error_count;
    compare_flag("buffer_dtr", buffer_dtr, 1'b1);
    compare_flag("move_done", move_done, 1'b0);
    compare_mask("enable", enable, '0);
    compare_mask("brake", brake, '0);
    compare_mask("step", step, '0);
    status_read(`MC_STATUS_VERSION, resp);
    compare_word("status version", resp,
        motion_pkg::word_t'({`MC_VERSION_MAJOR, `MC_VERSION_MINOR, `MC_VERSION_PATCH}));
    status_read(`MC_STATUS_CHANNELS, resp);
    compare_word("status channels", resp, 64'd2);
    report_test("after_reset", errs);
  endtask

  task automatic config_round_trip();
    int errs;
    motion_pkg::word_t old;
    errs = error_count;
    config_access(`MC_CFG_ENABLE, 32'h3, old);
    config_access(`MC_CFG_BRAKE, 32'h1, old);
    config_access(`MC_CFG_CLOCKS, 32'd4, old);
    compare_word("divisor before write", old, 64'(`MC_DEFAULT_DIVISOR));
    config_access(`MC_CFG_ENABLE, 32'h3, old);
    compare_word("enable read back", old, 64'h3);
    config_access(`MC_CFG_BRAKE, 32'h1, old);
    compare_word("brake read back", old, 64'h1);
    config_access(`MC_CFG_CLOCKS, 32'd4, old);
    compare_word("divisor read back", old, 64'd4);
    compare_mask("enable", enable, 2'b11);
    compare_mask("brake", brake, 2'b01);
    report_test("config_round_trip", errs);
  endtask

  task automatic single_move();
    int errs;
    errs = error_count;
    clear_counters();
    send_move(2'b10, 32'd16, 64'd1 << 31, '0, 64'd1 << 30, '0);
    compare_mask("dir", dir, 2'b10);  // Slot still active
    wait_move_done(1);
    repeat (20) to_drive_point();
    check_steps();
    compare_count("move_done pulses", done_count, 32'd1);
    report_test("single_move", errs);
  endtask

  task automatic back_to_back_moves();
    int errs;
    errs = error_count;
    clear_counters();
    send_move(2'b01, 32'd20, 64'hc000_0000, '0, 64'h5555_5555, '0);
    send_move(2'b11, 32'd12, 64'h4000_0000, '0, 64'h6000_0000, '0);
    compare_flag("buffer_dtr", buffer_dtr, 1'b0);  // Both slots taken
    wait_move_done(2);
    repeat (20) to_drive_point();
    check_steps();
    compare_count("move_done pulses", done_count, 32'd2);
    report_test("back_to_back_moves", errs);
  endtask

  task automatic accelerated_move();
    int errs;
    errs = error_count;
    clear_counters();
    send_move(2'b00, 32'd16, '0, 64'd1 << 28, '0, 64'd1 << 27);
    wait_move_done(1);
    repeat (20) to_drive_point();
    check_steps();
    report_test("accelerated_move", errs);
  endtask

  task automatic unknown_commands();
    int errs;
    motion_pkg::header_t hdr;
    motion_pkg::word_t w;
    motion_pkg::word_t resp;
    errs = error_count;
    status_read(`MC_STATUS_VERSION, resp);  // Leaves a nonzero answer behind
    for (int i = 0; i < 10; i++) begin
      do begin
        hdr = motion_pkg::header_t'($urandom);
      end while (hdr == `MC_CMD_MOVE || hdr == `MC_CMD_STATUS || hdr == `MC_CMD_CONFIG);
      w = {$urandom, $urandom};
      w[`MC_WORD_BITS-1 -: 8] = hdr;
      send_word(w, resp);
      compare_word("unknown header answer", resp, '0);
    end
    status_read(8'd9, resp);
    compare_word("status address 9", resp, '0);
    report_test("unknown_commands", errs);
  endtask

//--- test/motion_core_tb.sv
// Drives word_received as a plain level; step counts assume the motors are enabled by the tests
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module motion_core_tb;

  localparam int CLK_PERIOD = 100;
  localparam int WAIT_LIMIT = 2000;  // Cycles allowed per wait loop

  logic CLK;
  logic resetn;
  motion_pkg::word_t word_data_received;
  logic word_received;
  motion_pkg::word_t word_send_data;
  motion_pkg::motor_mask_t step;
  motion_pkg::motor_mask_t dir;
  motion_pkg::motor_mask_t enable;
  motion_pkg::motor_mask_t brake;
  logic buffer_dtr;
  logic move_done;

  int error_count;
  int check_count;
  int test_count;
  int failed_tests;
  motion_pkg::duration_t step_count [`MC_NUM_MOTORS];
  motion_pkg::duration_t expected_count [`MC_NUM_MOTORS];
  motion_pkg::duration_t done_count;
  logic [`MC_DDA_BITS-1:0] position_model [`MC_NUM_MOTORS];  // Expected accumulator values

  motion_core u_motion_core (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .step               (step),
    .dir                (dir),
    .enable             (enable),
    .brake              (brake),
    .buffer_dtr         (buffer_dtr),
    .move_done          (move_done)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Pulses sampled half a cycle away from the edge that makes them
  always @(negedge CLK) begin
    for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
      if (step[m] === 1'b1) step_count[m] = step_count[m] + 1;
    end
    if (move_done === 1'b1) done_count = done_count + 1;
  end

  task automatic to_drive_point();
    @(posedge CLK);
    #5;
  endtask

  task automatic compare_word(input string name, input motion_pkg::word_t got,
                              input motion_pkg::word_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_mask(input string name, input motion_pkg::motor_mask_t got,
                              input motion_pkg::motor_mask_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_count(input string name, input motion_pkg::duration_t got,
                               input motion_pkg::duration_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t: %s never happened", $time, what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  // Word stays on the bus until word_received has dropped
  task automatic send_word(input motion_pkg::word_t w, output motion_pkg::word_t resp);
    to_drive_point();
    word_data_received = w;
    word_received = 1'b1;
    repeat (3) to_drive_point();
    word_received = 1'b0;
    repeat (2) to_drive_point();
    resp = word_send_data;
  endtask

  task automatic wait_buffer_ready();
    int n;
    n = 0;
    while (buffer_dtr !== 1'b1) begin
      if (n >= WAIT_LIMIT) abort_on_timeout("buffer_dtr going high");
      to_drive_point();
      n++;
    end
  endtask

  task automatic wait_move_done(input motion_pkg::duration_t target);
    int n;
    n = 0;
    while (done_count < target) begin
      if (n >= WAIT_LIMIT) abort_on_timeout("the expected move_done pulses");
      to_drive_point();
      n++;
    end
  endtask

  task automatic clear_counters();
    for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
      step_count[m] = '0;
      expected_count[m] = '0;
    end
    done_count = '0;
  endtask

  task automatic report_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d errors", name, error_count - errors_before);
    end
  endtask

  `include "motion_core_tests.svh"

  initial begin
    void'($urandom(32'h1bd6));
    resetn = 1'b0;
    word_data_received = '0;
    word_received = 1'b0;
    error_count = 0;
    check_count = 0;
    test_count = 0;
    failed_tests = 0;
    for (int m = 0; m < `MC_NUM_MOTORS; m++) position_model[m] = '0;
    clear_counters();
    repeat (10) to_drive_point();
    resetn = 1'b1;

    after_reset();
    config_round_trip();
    single_move();
    back_to_back_moves();
    accelerated_move();
    unknown_commands();

    $display("Tests: %0d, failing tests: %0d, checks: %0d, errors: %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/motion_core.sv
// Host must wait for buffer_dtr before a move and hold each word until word_received falls
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module motion_core (
  input  wire                           CLK,
  input  wire                           resetn,
  input  wire motion_pkg::word_t        word_data_received,
  input  wire                           word_received,
  output motion_pkg::word_t             word_send_data,
  output motion_pkg::motor_mask_t       step,
  output motion_pkg::motor_mask_t       dir,
  output motion_pkg::motor_mask_t       enable,
  output motion_pkg::motor_mask_t       brake,
  output logic                          buffer_dtr,
  output logic                          move_done
);

  motion_pkg::divisor_t divisor;
  motion_pkg::motor_mask_t axis_step;
  logic tick;
  logic loading_move;
  logic executing_move;

  move_buffer_if u_mv ();

  word_command_decoder u_decoder (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .word_send_data     (word_send_data),
    .enable             (enable),
    .brake              (brake),
    .divisor            (divisor),
    .dir                (dir),
    .mv                 (u_mv)
  );

  dda_sequencer u_sequencer (
    .CLK            (CLK),
    .resetn         (resetn),
    .divisor        (divisor),
    .mv             (u_mv),
    .tick           (tick),
    .loading_move   (loading_move),
    .executing_move (executing_move),
    .move_done      (move_done),
    .buffer_dtr     (buffer_dtr)
  );

  for (genvar g = 0; g < `MC_NUM_MOTORS; g++) begin : g_axis
    dda_axis #(.AXIS(g)) u_axis (
      .CLK            (CLK),
      .resetn         (resetn),
      .tick           (tick),
      .loading_move   (loading_move),
      .executing_move (executing_move),
      .mv             (u_mv),
      .step_pulse     (axis_step[g])
    );
  end

  assign step = axis_step & enable;  // Disabled motors stay quiet

endmodule

`default_nettype wire

//--- rtl/dda_axis.sv
// Position carries over between moves; direction comes from dir, not from the sign
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module dda_axis #(
  parameter int AXIS = 0  // Motor index into the slot arrays
) (
  input  wire         CLK,
  input  wire         resetn,
  input  wire         tick,
  input  wire         loading_move,
  input  wire         executing_move,
  move_buffer_if.axis mv,
  output logic        step_pulse
);

  motion_pkg::dda_t velocity;
  motion_pkg::dda_t position;
  motion_pkg::dda_t position_next;

  assign position_next = position + velocity;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      velocity <= '0;
      position <= '0;
      step_pulse <= 1'b0;
    end else begin
      step_pulse <= 1'b0;
      if (tick && loading_move) begin
        velocity <= mv.increment[AXIS];  // Position keeps its fraction
      end else if (tick && executing_move) begin
        position <= position_next;
        velocity <= velocity + mv.acceleration[AXIS];
        // One step per crossing of the integer boundary
        step_pulse <= position_next[`MC_STEP_FRAC_BITS] ^ position[`MC_STEP_FRAC_BITS];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dda_sequencer.sv
// Divisor 0 or 1 ticks every cycle; a zero-length move finishes on its load tick
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module dda_sequencer (
  input  wire                        CLK,
  input  wire                        resetn,
  input  wire motion_pkg::divisor_t  divisor,
  move_buffer_if.sequencer           mv,
  output logic                       tick,
  output logic                       loading_move,
  output logic                       executing_move,
  output logic                       move_done,
  output logic                       buffer_dtr
);

  motion_pkg::divisor_t tick_cnt;
  motion_pkg::seq_state_t state;
  motion_pkg::duration_t ticks_left;
  logic [`MC_BUFFER_SIZE-1:0] consumed;  // Matches stepready once a slot has run
  logic move_pending;
  logic finish;

  assign move_pending = mv.stepready[mv.moveind] != consumed[mv.moveind];
  assign buffer_dtr = |(~(mv.stepready ^ consumed));  // Any slot free
  assign loading_move = (state == motion_pkg::SEQ_LOAD);
  assign executing_move = (state == motion_pkg::SEQ_EXEC);
  assign finish = tick && ((loading_move && mv.duration == '0) ||
                           (executing_move && ticks_left == 32'd1));

  // Tick divider
  always_ff @(posedge CLK) begin
    if (!resetn) begin
      tick_cnt <= '0;
      tick <= 1'b0;
    end else if (divisor <= 8'd1 || tick_cnt >= divisor - 8'd1) begin
      tick_cnt <= '0;
      tick <= 1'b1;
    end else begin
      tick_cnt <= tick_cnt + 8'd1;
      tick <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state <= motion_pkg::SEQ_IDLE;
      ticks_left <= '0;
      consumed <= '0;
      mv.moveind <= '0;
      move_done <= 1'b0;
    end else begin
      move_done <= finish;
      if (finish) begin
        state <= motion_pkg::SEQ_IDLE;
        consumed[mv.moveind] <= ~consumed[mv.moveind];
        mv.moveind <= mv.moveind + 1'b1;
      end else begin
        case (state)
          motion_pkg::SEQ_IDLE: if (move_pending) state <= motion_pkg::SEQ_LOAD;
          motion_pkg::SEQ_LOAD: begin
            if (tick) begin
              state <= motion_pkg::SEQ_EXEC;
              ticks_left <= mv.duration;
            end
          end
          motion_pkg::SEQ_EXEC: if (tick) ticks_left <= ticks_left - 32'd1;
          default: state <= motion_pkg::SEQ_IDLE;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/word_command_decoder.sv
// Config access always takes two words and the header word answers the old value
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

module word_command_decoder (
  input  wire                           CLK,
  input  wire                           resetn,
  input  wire motion_pkg::word_t        word_data_received,
  input  wire                           word_received,
  output motion_pkg::word_t             word_send_data,
  output motion_pkg::motor_mask_t       enable,
  output motion_pkg::motor_mask_t       brake,
  output motion_pkg::divisor_t          divisor,
  output motion_pkg::motor_mask_t       dir,
  move_buffer_if.decoder                mv
);

  localparam int unsigned MOVE_WORDS = 1 + 2 * `MC_NUM_MOTORS;  // Duration, then inc/acc pairs

  logic wr_sync;
  logic wr_prev;
  logic word_rising;
  motion_pkg::header_t msg_header;  // Nonzero while a multi-word message is open
  logic [2:0] word_count;
  logic [7:0] cfg_addr;
  motion_pkg::slot_t write_ind;
  logic [`MC_BUFFER_SIZE-1:0] stepready_r;

  // Move buffer storage
  motion_pkg::duration_t duration_r [`MC_BUFFER_SIZE];
  motion_pkg::dda_t increment_r [`MC_BUFFER_SIZE][`MC_NUM_MOTORS];
  motion_pkg::dda_t accel_r [`MC_BUFFER_SIZE][`MC_NUM_MOTORS];
  motion_pkg::motor_mask_t dir_r [`MC_BUFFER_SIZE];

  motion_pkg::header_t rx_header;
  motion_pkg::word_t status_word;
  motion_pkg::word_t config_word;

  assign rx_header = word_data_received[`MC_WORD_BITS-1 -: 8];
  assign word_rising = wr_sync & ~wr_prev;  // Lands the answer on the second edge

  // Status registers are constants
  always_comb begin
    status_word = '0;
    case (word_data_received[7:0])
      `MC_STATUS_VERSION:
        status_word[23:0] = {`MC_VERSION_MAJOR, `MC_VERSION_MINOR, `MC_VERSION_PATCH};
      `MC_STATUS_CHANNELS: status_word[7:0] = 8'(`MC_NUM_MOTORS);
      default: ;
    endcase
  end

  always_comb begin
    config_word = '0;
    case (word_data_received[7:0])
      `MC_CFG_ENABLE: config_word[`MC_NUM_MOTORS-1:0] = enable;
      `MC_CFG_BRAKE:  config_word[`MC_NUM_MOTORS-1:0] = brake;
      `MC_CFG_CLOCKS: config_word[7:0] = divisor;
      default: ;
    endcase
  end

  // Present the slot picked by the sequencer
  always_comb begin
    mv.duration = duration_r[mv.moveind];
    mv.dir = dir_r[mv.moveind];
    for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
      mv.increment[m] = increment_r[mv.moveind][m];
      mv.acceleration[m] = accel_r[mv.moveind][m];
    end
  end

  assign mv.stepready = stepready_r;
  assign dir = mv.dir;

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      wr_sync <= 1'b0;
      wr_prev <= 1'b0;
      msg_header <= '0;
      word_count <= '0;
      write_ind <= '0;
      stepready_r <= '0;
      word_send_data <= '0;
      enable <= '0;
      brake <= '0;
      divisor <= `MC_DEFAULT_DIVISOR;
    end else begin
      wr_sync <= word_received;
      wr_prev <= wr_sync;
      if (word_rising) begin
        word_send_data <= '0;  // Default answer
        if (msg_header == '0) begin
          word_count <= 3'd1;
          case (rx_header)
            `MC_CMD_MOVE: msg_header <= rx_header;
            `MC_CMD_CONFIG: begin
              msg_header <= rx_header;
              word_send_data <= config_word;
            end
            `MC_CMD_STATUS: word_send_data <= status_word;
            default: ;
          endcase
        end else if (msg_header == `MC_CMD_CONFIG) begin
          msg_header <= '0;
          word_count <= '0;
          case (cfg_addr)
            `MC_CFG_ENABLE: enable <= word_data_received[`MC_NUM_MOTORS-1:0];
            `MC_CFG_BRAKE:  brake <= word_data_received[`MC_NUM_MOTORS-1:0];
            `MC_CFG_CLOCKS: divisor <= word_data_received[7:0];
            default: ;
          endcase
        end else if (word_count == 3'(MOVE_WORDS)) begin
          // Last move word hands the slot over
          msg_header <= '0;
          word_count <= '0;
          write_ind <= write_ind + 1'b1;
          stepready_r[write_ind] <= ~stepready_r[write_ind];
        end else begin
          word_count <= word_count + 3'd1;
        end
      end
    end
  end

  // Payload capture
  always_ff @(posedge CLK) begin
    if (word_rising && msg_header == '0) begin
      cfg_addr <= word_data_received[7:0];
      if (rx_header == `MC_CMD_MOVE)
        dir_r[write_ind] <= word_data_received[`MC_NUM_MOTORS-1:0];
    end
    if (word_rising && msg_header == `MC_CMD_MOVE) begin
      if (word_count == 3'd1)
        duration_r[write_ind] <= word_data_received[`MC_DURATION_BITS-1:0];
      for (int m = 0; m < `MC_NUM_MOTORS; m++) begin
        if (word_count == 3'(2 + 2 * m))
          increment_r[write_ind][m] <= word_data_received;
        if (word_count == 3'(3 + 2 * m))
          accel_r[write_ind][m] <= word_data_received;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/move_buffer_if.sv
// Slot contents are muxed by moveind in the decoder, so readers see only the active move
`timescale 1ns/1ps
`default_nettype none

`include "motion_params.svh"

interface move_buffer_if;

  logic [`MC_BUFFER_SIZE-1:0] stepready;  // Toggled per slot when filled
  motion_pkg::duration_t duration;
  motion_pkg::dda_t increment [`MC_NUM_MOTORS];
  motion_pkg::dda_t acceleration [`MC_NUM_MOTORS];
  motion_pkg::motor_mask_t dir;
  motion_pkg::slot_t moveind;  // Slot under execution

  modport decoder (
    output stepready, duration, increment, acceleration, dir,
    input  moveind
  );

  modport sequencer (input stepready, duration, output moveind);

  modport axis (input increment, acceleration);

endinterface

`default_nettype wire

//--- rtl/motion_pkg.sv
// Types only; the widths come from the params header, which must be on the include path
`default_nettype none

`include "motion_params.svh"

package motion_pkg;

  // Bus word as seen by the host
  typedef logic [`MC_WORD_BITS-1:0] word_t;

  // DDA increments and accumulators are two's complement
  typedef logic signed [`MC_DDA_BITS-1:0] dda_t;

  typedef logic [`MC_DURATION_BITS-1:0] duration_t;  // Move length in ticks

  typedef logic [`MC_NUM_MOTORS-1:0] motor_mask_t;  // One bit per motor

  typedef logic [$clog2(`MC_BUFFER_SIZE)-1:0] slot_t;

  typedef logic [7:0] divisor_t;
  typedef logic [7:0] header_t;

  // Sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,  // One tick for the axes to pick up the new increment
    SEQ_EXEC
  } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/motion_params.svh
// Sizes are fixed for two motors and a two-slot buffer; register indices are 8-bit addresses
`ifndef MOTION_PARAMS_SVH
`define MOTION_PARAMS_SVH

// Datapath widths
`define MC_WORD_BITS 64
`define MC_DDA_BITS 64
`define MC_DURATION_BITS 32
`define MC_NUM_MOTORS 2
`define MC_BUFFER_SIZE 2
`define MC_STEP_FRAC_BITS 32  // Step fires when this accumulator bit toggles

// Command headers sit in bits 63:56 of the first word
`define MC_CMD_MOVE 8'h01
`define MC_CMD_STATUS 8'hf1
`define MC_CMD_CONFIG 8'hf2

// Config register addresses
`define MC_CFG_ENABLE 8'd0
`define MC_CFG_BRAKE 8'd1
`define MC_CFG_CLOCKS 8'd2

// Status register addresses
`define MC_STATUS_VERSION 8'd0
`define MC_STATUS_CHANNELS 8'd1

`define MC_VERSION_MAJOR 8'd0
`define MC_VERSION_MINOR 8'd2
`define MC_VERSION_PATCH 8'd1

`define MC_DEFAULT_DIVISOR 8'd32  // Tick divisor out of reset

`endif
